// ==== src/sdramPkg.sv ====
//////////////////////////////
// shared encodings for a 16-bit, 4-bank, 8192-row SDRAM, CAS latency 2
// command codes are packed as {CKE, CS_L, RAS_L, CAS_L, WE_L}
// activate, read and write codes are defined but not issued by this controller
//////////////////////////////

package sdramPkg;

	//////////////////////////////
	// vector types
	//////////////////////////////

	typedef logic [4:0]  sdramCmdT;                   // cke, cs, ras, cas, we
	typedef logic [12:0] rowAddrT;                    // A12..A0
	typedef logic [1:0]  bankT;                       // BA1..BA0
	typedef logic [15:0] timerT;                      // timer count in clocks

	//////////////////////////////
	// command codes
	//////////////////////////////

	localparam sdramCmdT CmdPowerUp      = 5'b00000;  // cke and cs low, chip held off
	localparam sdramCmdT CmdNop          = 5'b10111;
	localparam sdramCmdT CmdPrechargeAll = 5'b10010;  // needs A10 high
	localparam sdramCmdT CmdAutoRefresh  = 5'b10001;
	localparam sdramCmdT CmdModeSet      = 5'b10000;  // address carries the mode word
	localparam sdramCmdT CmdActivate     = 5'b10011;  // reserved for a later access path
	localparam sdramCmdT CmdRead         = 5'b10101;  // reserved, A10 selects auto precharge
	localparam sdramCmdT CmdWrite        = 5'b10100;  // reserved, A10 selects auto precharge

	//////////////////////////////
	// address values
	//////////////////////////////

	// A10 set selects all banks on a precharge
	localparam rowAddrT PrechargeAllAddr = 13'h0400;

	// mode register
	//   A2..A0 = 000  burst length 1
	//   A3     = 0    sequential
	//   A6..A4 = 010  cas latency 2
	//   A9     = 0    with burst length 1 every write is single location
	localparam rowAddrT ModeWord = 13'h020;

	localparam bankT ModeBank = 2'b00;                // base mode register, not extended

endpackage

// ==== src/sdramTimer.sv ====
//////////////////////////////
// loadable down counter, stops at zero
// Done is combinational and is high straight out of reset
//////////////////////////////

`timescale 1ns/100ps

module sdramTimer
	import sdramPkg::*;
(
	input  logic  Clock,
	input  logic  Reset_L,
	input  logic  Load,                        // load on next edge
	input  timerT LoadValue,
	output logic  Done                         // high while count is zero
);

	timerT count;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;                       // starts expired
		end else if (Load) begin
			count <= LoadValue;
		end else if (count != '0) begin
			count <= count - timerT'(1);       // hold once at zero
		end
	end

	assign Done = (count == '0);

endmodule

// ==== src/sdramSequencer.sv ====
//////////////////////////////
// power-up, initialisation and periodic refresh FSM, one state per clock
// outputs are combinational from state and counters, registered later
// RefreshGap and InitRefreshes must both be at least 1
//////////////////////////////

`timescale 1ns/100ps

module sdramSequencer
	import sdramPkg::*;
#(
	parameter timerT      PowerUpCycles   = 16'd5000,   // 100 us at 50 MHz
	parameter logic [3:0] InitRefreshes   = 4'd8,
	parameter logic [3:0] RefreshGap      = 4'd3,       // nops after a refresh, covers tRC
	parameter timerT      RefreshInterval = 16'd375     // 7.5 us at 50 MHz
) (
	input  logic     Clock,
	input  logic     Reset_L,
	input  logic     PowerUpDone,           // power-up timer expired
	input  logic     RefreshDue,            // refresh timer expired
	output logic     PowerUpLoad,
	output timerT    PowerUpValue,
	output logic     RefreshLoad,
	output timerT    RefreshValue,
	output sdramCmdT NextCmd,
	output rowAddrT  NextAddr,
	output bankT     NextBank,
	output logic     Ready                  // init finished, cpu may run
);

	localparam logic [3:0] GapLoad = RefreshGap - 4'd1;  // gap counts down to zero

	typedef enum logic [3:0] {
		PowerUpStart,
		PowerUpWait,
		FirstNop,
		InitPrecharge,
		InitNop,
		InitRefresh,
		InitGap,
		ModeSet,
		ModeGap,
		Idle,
		RefPrecharge,
		RefNop,
		RefRefresh,
		RefGap
	} seqStateT;

	seqStateT   state;
	seqStateT   nextState;
	logic [3:0] gapCount;                  // nop cycles left in a gap
	logic [3:0] refreshCount;              // init refreshes issued so far
	logic       gapDone;

	assign gapDone = (gapCount == 4'd0);

	//////////////////////////////
	// state and counters
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state        <= PowerUpStart;
			gapCount     <= 4'd0;
			refreshCount <= 4'd0;
		end else begin
			state <= nextState;
			case (state)
				InitRefresh: begin
					refreshCount <= refreshCount + 4'd1;   // counts this refresh
					gapCount     <= GapLoad;
				end
				ModeSet, RefRefresh: begin
					gapCount <= GapLoad;
				end
				InitGap, ModeGap, RefGap: begin
					if (!gapDone)
						gapCount <= gapCount - 4'd1;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// next state and command
	//////////////////////////////

	assign PowerUpValue = PowerUpCycles;
	assign RefreshValue = RefreshInterval;
	assign PowerUpLoad  = (state == PowerUpStart);
	// reload on the last gap cycle so the interval starts with idle
	assign RefreshLoad  = ((state == ModeGap) || (state == RefGap)) && gapDone;

	always_comb begin
		nextState = state;
		NextCmd   = CmdNop;                    // nop unless a state says otherwise
		NextAddr  = '0;
		NextBank  = '0;
		Ready     = 1'b0;
		case (state)
			PowerUpStart: begin
				NextCmd   = CmdPowerUp;        // timer loads on this edge
				nextState = PowerUpWait;
			end
			PowerUpWait: begin
				NextCmd = CmdPowerUp;          // cke stays low until the wait ends
				if (PowerUpDone)
					nextState = FirstNop;
			end
			FirstNop: begin
				nextState = InitPrecharge;
			end
			InitPrecharge: begin
				NextCmd   = CmdPrechargeAll;
				NextAddr  = PrechargeAllAddr;
				nextState = InitNop;
			end
			InitNop: begin
				nextState = InitRefresh;       // covers tRP
			end
			InitRefresh: begin
				NextCmd   = CmdAutoRefresh;
				nextState = InitGap;
			end
			InitGap: begin
				if (gapDone) begin
					if (refreshCount == InitRefreshes)
						nextState = ModeSet;
					else
						nextState = InitRefresh;
				end
			end
			ModeSet: begin
				NextCmd   = CmdModeSet;
				NextAddr  = ModeWord;
				NextBank  = ModeBank;
				nextState = ModeGap;
			end
			ModeGap: begin
				if (gapDone)
					nextState = Idle;
			end
			Idle: begin
				Ready = 1'b1;
				if (RefreshDue)
					nextState = RefPrecharge;
			end
			RefPrecharge: begin
				Ready     = 1'b1;
				NextCmd   = CmdPrechargeAll;   // close any open row first
				NextAddr  = PrechargeAllAddr;
				nextState = RefNop;
			end
			RefNop: begin
				Ready     = 1'b1;
				nextState = RefRefresh;
			end
			RefRefresh: begin
				Ready     = 1'b1;
				NextCmd   = CmdAutoRefresh;
				nextState = RefGap;
			end
			RefGap: begin
				Ready = 1'b1;
				if (gapDone)
					nextState = Idle;
			end
			default: begin
				nextState = PowerUpStart;
			end
		endcase
	end

endmodule

// ==== src/sdramPinDriver.sv ====
//////////////////////////////
// output register stage for the SDRAM pins and the cpu reset
// one clock from Next* inputs to the pins, reset parks the chip in power-up
//////////////////////////////

`timescale 1ns/100ps

module sdramPinDriver
	import sdramPkg::*;
(
	input  logic     Clock,
	input  logic     Reset_L,
	input  sdramCmdT NextCmd,
	input  rowAddrT  NextAddr,
	input  bankT     NextBank,
	input  logic     Ready,
	output logic     SdramCke,
	output logic     SdramCs_L,
	output logic     SdramRas_L,
	output logic     SdramCas_L,
	output logic     SdramWe_L,
	output rowAddrT  SdramAddr,
	output bankT     SdramBa,
	output logic     ResetOut_L            // cpu held in reset until init done
);

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} <= CmdPowerUp;
			SdramAddr  <= '0;
			SdramBa    <= '0;
			ResetOut_L <= 1'b0;
		end else begin
			// command bit order matches the package
			SdramCke   <= NextCmd[4];
			SdramCs_L  <= NextCmd[3];
			SdramRas_L <= NextCmd[2];
			SdramCas_L <= NextCmd[1];
			SdramWe_L  <= NextCmd[0];
			SdramAddr  <= NextAddr;
			SdramBa    <= NextBank;
			ResetOut_L <= Ready;           // lags the sequencer like the pins
		end
	end

endmodule

// ==== src/sdramTop.sv ====
//////////////////////////////
// SDRAM controller top, init and refresh only, no data path
// defaults assume a 50 MHz clock, shrink the timing parameters for simulation
//////////////////////////////

`timescale 1ns/100ps

module sdramTop
	import sdramPkg::*;
#(
	parameter timerT      PowerUpCycles   = 16'd5000,   // 100 us
	parameter logic [3:0] InitRefreshes   = 4'd8,
	parameter logic [3:0] RefreshGap      = 4'd3,
	parameter timerT      RefreshInterval = 16'd375     // 7.5 us
) (
	input  logic    Clock,
	input  logic    Reset_L,
	output logic    SdramCke,
	output logic    SdramCs_L,
	output logic    SdramRas_L,
	output logic    SdramCas_L,
	output logic    SdramWe_L,
	output rowAddrT SdramAddr,
	output bankT    SdramBa,
	output logic    ResetOut_L
);

	logic     powerUpLoad;
	timerT    powerUpValue;
	logic     powerUpDone;
	logic     refreshLoad;
	timerT    refreshValue;
	logic     refreshDue;
	sdramCmdT nextCmd;
	rowAddrT  nextAddr;
	bankT     nextBank;
	logic     ready;

	//////////////////////////////
	// timers
	//////////////////////////////

	sdramTimer powerUpTimer_i (
		.Clock     (Clock),
		.Reset_L   (Reset_L),
		.Load      (powerUpLoad),
		.LoadValue (powerUpValue),
		.Done      (powerUpDone)
	);

	sdramTimer refreshTimer_i (
		.Clock     (Clock),
		.Reset_L   (Reset_L),
		.Load      (refreshLoad),
		.LoadValue (refreshValue),
		.Done      (refreshDue)
	);

	//////////////////////////////
	// control and pins
	//////////////////////////////

	sdramSequencer #(
		.PowerUpCycles   (PowerUpCycles),
		.InitRefreshes   (InitRefreshes),
		.RefreshGap      (RefreshGap),
		.RefreshInterval (RefreshInterval)
	) sequencer_i (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.PowerUpDone  (powerUpDone),
		.RefreshDue   (refreshDue),
		.PowerUpLoad  (powerUpLoad),
		.PowerUpValue (powerUpValue),
		.RefreshLoad  (refreshLoad),
		.RefreshValue (refreshValue),
		.NextCmd      (nextCmd),
		.NextAddr     (nextAddr),
		.NextBank     (nextBank),
		.Ready        (ready)
	);

	sdramPinDriver pinDriver_i (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.NextCmd    (nextCmd),
		.NextAddr   (nextAddr),
		.NextBank   (nextBank),
		.Ready      (ready),
		.SdramCke   (SdramCke),
		.SdramCs_L  (SdramCs_L),
		.SdramRas_L (SdramRas_L),
		.SdramCas_L (SdramCas_L),
		.SdramWe_L  (SdramWe_L),
		.SdramAddr  (SdramAddr),
		.SdramBa    (SdramBa),
		.ResetOut_L (ResetOut_L)
	);

endmodule

// ==== test/sdramTop_checker.sv ====
//////////////////////////////
// concurrent assertions on the SDRAM pins and ResetOut_L, bound into sdramTop
// counters assume one command per clock and a single mode register set
// the gap limit only starts after the first periodic refresh
//////////////////////////////

`timescale 1ns/100ps

module sdramTop_checker
	import sdramPkg::*;
#(
	parameter timerT      PowerUpCycles   = 16'd5000,
	parameter logic [3:0] InitRefreshes   = 4'd8,
	parameter logic [3:0] RefreshGap      = 4'd3,
	parameter timerT      RefreshInterval = 16'd375
) (
	input logic    Clock,
	input logic    Reset_L,
	input logic    SdramCke,
	input logic    SdramCs_L,
	input logic    SdramRas_L,
	input logic    SdramCas_L,
	input logic    SdramWe_L,
	input rowAddrT SdramAddr,
	input bankT    SdramBa,
	input logic    ResetOut_L
);

	sdramCmdT cmd;
	int       sinceReset;                  // clocks since reset release, saturates
	int       sinceRefresh;                // clocks since the last auto-refresh
	int       initRefreshes;               // refreshes before the mode set
	logic     modeSeen;
	logic     refreshSeen;
	logic     periodicSeen;                // a refresh seen with the cpu running

	assign cmd = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			sinceReset    <= 0;
			sinceRefresh  <= 0;
			initRefreshes <= 0;
			modeSeen      <= 1'b0;
			refreshSeen   <= 1'b0;
			periodicSeen  <= 1'b0;
		end else begin
			if (sinceReset <= int'(PowerUpCycles) + 2)
				sinceReset <= sinceReset + 1;
			if (cmd == CmdAutoRefresh) begin
				sinceRefresh <= 0;
				refreshSeen  <= 1'b1;
				if (!modeSeen)
					initRefreshes <= initRefreshes + 1;
				if (ResetOut_L)
					periodicSeen <= 1'b1;
			end else if (sinceRefresh < 65535) begin
				sinceRefresh <= sinceRefresh + 1;
			end
			if (cmd == CmdModeSet)
				modeSeen <= 1'b1;
		end
	end

	//////////////////////////////
	// power-up and init order
	//////////////////////////////

	assert property (@(posedge Clock) !Reset_L |-> cmd == 5'b00000 && !ResetOut_L
		&& SdramAddr == '0 && SdramBa == '0)
		else $error("Mismatch at %0t: pins not parked during reset", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		sinceReset <= int'(PowerUpCycles) + 2 |-> cmd == 5'b00000 && !ResetOut_L)
		else $error("Mismatch at %0t: power-up wait ended early", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		sinceReset > int'(PowerUpCycles) + 2 |-> SdramCke)
		else $error("Mismatch at %0t: cke low after the power-up wait", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		$past(cmd) == CmdPowerUp && cmd != CmdPowerUp |-> cmd == CmdNop)
		else $error("Mismatch at %0t: first command after power-up not a nop", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		$past(cmd, 2) == CmdPowerUp && $past(cmd) == CmdNop
		|-> cmd == CmdPrechargeAll && SdramAddr[10])
		else $error("Mismatch at %0t: no precharge all after the first nop", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		cmd == CmdModeSet |-> !modeSeen && initRefreshes == int'(InitRefreshes)
		&& SdramAddr == 13'h020 && SdramBa == 2'b00)
		else $error("Mismatch at %0t: bad mode set, %0d init refreshes", $time,
			initRefreshes);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		!modeSeen && refreshSeen && cmd != CmdAutoRefresh && cmd != CmdModeSet
		|-> cmd == CmdNop)
		else $error("Mismatch at %0t: non-nop between init refreshes", $time);

	//////////////////////////////
	// cpu reset and refresh
	//////////////////////////////

	assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(ResetOut_L) |-> modeSeen && $past(cmd, int'(RefreshGap) + 1) == CmdModeSet)
		else $error("Mismatch at %0t: ResetOut_L rose at the wrong time", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L) $past(ResetOut_L) |-> ResetOut_L)
		else $error("Mismatch at %0t: ResetOut_L fell while out of reset", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		cmd == CmdAutoRefresh && refreshSeen |-> sinceRefresh >= int'(RefreshGap))
		else $error("Mismatch at %0t: refreshes only %0d clocks apart", $time,
			sinceRefresh + 1);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		ResetOut_L && cmd == CmdAutoRefresh
		|-> $past(cmd, 2) == CmdPrechargeAll && $past(SdramAddr[10], 2))
		else $error("Mismatch at %0t: periodic refresh without precharge", $time);

	assert property (@(posedge Clock) disable iff (!Reset_L)
		periodicSeen |-> sinceRefresh <= int'(RefreshInterval) + int'(RefreshGap) + 4)
		else $error("Mismatch at %0t: periodic refresh overdue", $time);

endmodule

bind sdramTop sdramTop_checker #(
	.PowerUpCycles   (PowerUpCycles),
	.InitRefreshes   (InitRefreshes),
	.RefreshGap      (RefreshGap),
	.RefreshInterval (RefreshInterval)
) checker_i (
	.Clock      (Clock),
	.Reset_L    (Reset_L),
	.SdramCke   (SdramCke),
	.SdramCs_L  (SdramCs_L),
	.SdramRas_L (SdramRas_L),
	.SdramCas_L (SdramCas_L),
	.SdramWe_L  (SdramWe_L),
	.SdramAddr  (SdramAddr),
	.SdramBa    (SdramBa),
	.ResetOut_L (ResetOut_L)
);

// ==== test/sdramTop_tb.sv ====
//////////////////////////////
// testbench for sdramTop with shortened power-up and refresh timing
// only reset is driven, the bound checker holds the assertions
// run ends after six periodic refreshes or at the cycle limit
//////////////////////////////

`timescale 1ns/100ps

module sdramTop_tb
	import sdramPkg::*;
();

	localparam timerT      PowerUpCycles   = 16'd20;
	localparam logic [3:0] InitRefreshes   = 4'd8;
	localparam logic [3:0] RefreshGap      = 4'd3;
	localparam timerT      RefreshInterval = 16'd40;

	localparam int ClockPeriod   = 8;
	localparam int DriveDelay    = 1;          // inputs change just after the edge
	localparam int ResetCycles   = 8;
	localparam int RefreshTarget = 6;          // periodic refreshes to watch
	// twice power-up, init and six refresh periods
	localparam int TimeoutCycles = 2 * (int'(PowerUpCycles)
		+ int'(InitRefreshes) * (int'(RefreshGap) + 1)
		+ RefreshTarget * (int'(RefreshInterval) + int'(RefreshGap) + 4));

	logic     Clock;
	logic     Reset_L;
	logic     SdramCke;
	logic     SdramCs_L;
	logic     SdramRas_L;
	logic     SdramCas_L;
	logic     SdramWe_L;
	rowAddrT  SdramAddr;
	bankT     SdramBa;
	logic     ResetOut_L;
	sdramCmdT pinCmd;                          // pins packed back into a command
	int       cycleCount = 0;
	int       periodicRefreshes;

	assign pinCmd = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};

	sdramTop #(
		.PowerUpCycles   (PowerUpCycles),
		.InitRefreshes   (InitRefreshes),
		.RefreshGap      (RefreshGap),
		.RefreshInterval (RefreshInterval)
	) dut_i (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.SdramCke   (SdramCke),
		.SdramCs_L  (SdramCs_L),
		.SdramRas_L (SdramRas_L),
		.SdramCas_L (SdramCas_L),
		.SdramWe_L  (SdramWe_L),
		.SdramAddr  (SdramAddr),
		.SdramBa    (SdramBa),
		.ResetOut_L (ResetOut_L)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	//////////////////////////////
	// watchdog
	//////////////////////////////

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			if (ResetOut_L !== 1'b1)
				stopWithFailure($sformatf("timeout at %0t: ResetOut_L never went high",
					$time));
			else
				stopWithFailure($sformatf("timeout at %0t: only %0d of %0d refreshes seen",
					$time, periodicRefreshes, RefreshTarget));
		end
	end

	//////////////////////////////
	// reset and run
	//////////////////////////////

	initial begin
		Clock             = 1'b0;
		Reset_L           = 1'b0;
		periodicRefreshes = 0;
		repeat (ResetCycles) @(posedge Clock);
		#DriveDelay Reset_L = 1'b1;
		while (ResetOut_L !== 1'b1) begin      // init running
			@(posedge Clock);
			#DriveDelay;
		end
		while (periodicRefreshes < RefreshTarget) begin
			@(posedge Clock);
			#DriveDelay;                       // pins settled after the edge
			if (pinCmd == CmdAutoRefresh)
				periodicRefreshes = periodicRefreshes + 1;
		end
		if (ResetOut_L !== 1'b1) begin
			stopWithFailure($sformatf("Mismatch at %0t: ResetOut_L low at end of run",
				$time));
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// ==== files.f ====
src/sdramPkg.sv
src/sdramTimer.sv
src/sdramSequencer.sv
src/sdramPinDriver.sv
src/sdramTop.sv
test/sdramTop_checker.sv
test/sdramTop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	-f files.f --top-module sdramTop_tb -o simv; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF -- '*** TEST PASSED ***' <<< "$output"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi
